// File: verilog/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// ==========================================================
// machine sizes for the rename / dispatch front
// ==========================================================

// architectural register file, x0..x31
`define ARCH_REGS 32

// physical register file
// the tags above ARCH_REGS form the initial free pool
`define PHYS_REGS 48

// reorder buffer entries, one per dispatched instruction
`define ROB_DEPTH 16

`endif

// File: verilog/rename_pkg.sv
`default_nettype none

`include "rename_macros.svh"

package rename_pkg;

    // ==========================================================
    // register and slot identifiers
    // ==========================================================

    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;  // 5 bits
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_tag_t;  // 6 bits
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;   // 4 bits

    // functional unit class, picks the reservation station
    typedef enum logic [1:0] {
        fu_alu    = 2'd0,  // integer ops, lui, auipc, system
        fu_mult   = 2'd1,  // M extension
        fu_mem    = 2'd2,  // loads and stores
        fu_branch = 2'd3   // conditional branches, jal, jalr
    } fu_type_t;

    // ==========================================================
    // reorder buffer entry
    // ==========================================================

    // only what commit needs to free the previous mapping
    typedef struct packed {
        logic      has_dest;   // entry renamed a register
        arch_reg_t dest_arch;  // architectural destination
        phys_tag_t old_tag;    // mapping it replaced, freed at commit
    } rob_entry_t;

endpackage

`default_nettype wire

// File: verilog/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input  wire logic [31:0]         inst_i,
    output rename_pkg::arch_reg_t    rs1_o,
    output rename_pkg::arch_reg_t    rs2_o,
    output rename_pkg::arch_reg_t    rd_o,
    output logic                     has_dest_o,  // instruction writes a register
    output rename_pkg::fu_type_t     fu_type_o
);

    // rv32 major opcodes that affect classification
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_REG    = 7'b0110011;  // register-register, incl. mul/div
    localparam logic [6:0] MULDIV_F7 = 7'b0000001;

    logic [6:0] opcode;
    logic [6:0] funct7;

    assign opcode = inst_i[6:0];
    assign funct7 = inst_i[31:25];

    // fixed field positions, extracted whether or not the format uses them
    assign rd_o  = inst_i[11:7];
    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];

    // stores and branches have no rd field, x0 is hardwired
    assign has_dest_o = (rd_o != '0) && (opcode != OP_STORE) && (opcode != OP_BRANCH);

    always_comb begin
        unique case (opcode)
            OP_LOAD, OP_STORE:          fu_type_o = rename_pkg::fu_mem;
            OP_BRANCH, OP_JAL, OP_JALR: fu_type_o = rename_pkg::fu_branch;
            OP_REG: begin
                // funct7 = 1 selects the M extension
                if (funct7 == MULDIV_F7)
                    fu_type_o = rename_pkg::fu_mult;
                else
                    fu_type_o = rename_pkg::fu_alu;
            end
            default:                    fu_type_o = rename_pkg::fu_alu;  // op-imm, lui, auipc, ...
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/circular_queue.sv
`timescale 1ns/1ns
`default_nettype none

module circular_queue #(
    parameter int unsigned DEPTH      = 16,
    parameter type         payload_t  = logic [7:0],
    parameter bit          RESET_FILL = 1'b0,  // start full with FILL_BASE, FILL_BASE+1, ...
    parameter int unsigned FILL_BASE  = 0
) (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic            push_i,
    input  payload_t             push_data_i,
    input  wire logic            pop_i,
    output payload_t             head_o,      // oldest entry, valid when not empty
    output logic                 empty_o,
    output logic                 full_o,
    output rename_pkg::rob_idx_t tail_idx_o   // slot the next push lands in
);

    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);
    localparam int W  = $bits(payload_t);

    logic [W-1:0]  mem [DEPTH];  // raw storage
    logic [PW-1:0] head_q;
    logic [PW-1:0] tail_q;
    logic [CW-1:0] count_q;

    // wrap for any depth, not only powers of two
    function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
        ptr_next = (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ==========================================================
    // pointers and occupancy
    // ==========================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;                                 // full queue wraps tail onto head
            count_q <= RESET_FILL ? CW'(DEPTH) : '0;
        end else begin
            if (push_i) tail_q <= ptr_next(tail_q);
            if (pop_i)  head_q <= ptr_next(head_q);
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;               // both or neither
            endcase
        end
    end

    // storage, only filled on reset when asked to
    always_ff @(posedge clock) begin
        if (reset && RESET_FILL) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= W'(FILL_BASE + i);
            end
        end else if (push_i) begin
            mem[tail_q] <= push_data_i;
        end
    end

    assign head_o     = payload_t'(mem[head_q]);
    assign empty_o    = (count_q == '0);
    assign full_o     = (count_q == CW'(DEPTH));
    assign tail_idx_o = rename_pkg::rob_idx_t'(tail_q);

    // a full queue takes a push only together with a pop
    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        push_i |-> (!full_o || pop_i));

    a_no_underflow: assert property (@(posedge clock) disable iff (reset)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

// File: verilog/map_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module map_table (
    input  wire logic             clock,
    input  wire logic             reset,
    input  rename_pkg::arch_reg_t rs1_i,
    input  rename_pkg::arch_reg_t rs2_i,
    input  rename_pkg::arch_reg_t rd_i,
    input  wire logic             write_i,      // rename rd_i to write_tag_i
    input  rename_pkg::phys_tag_t write_tag_i,
    output rename_pkg::phys_tag_t rs1_tag_o,
    output rename_pkg::phys_tag_t rs2_tag_o,
    output rename_pkg::phys_tag_t old_tag_o     // current mapping of rd, becomes Told
);

    // speculative architectural -> physical mapping
    rename_pkg::phys_tag_t map_q [`ARCH_REGS];

    // ==========================================================
    // update
    // ==========================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            // identity, tags 0..31 hold the architectural state
            for (int r = 0; r < `ARCH_REGS; r++) begin
                map_q[r] <= rename_pkg::phys_tag_t'(r);
            end
        end else if (write_i) begin
            map_q[rd_i] <= write_tag_i;  // visible to the next instruction
        end
    end

    // ==========================================================
    // lookups
    // ==========================================================

    // no bypass of a same-cycle write
    // the dispatch stage writes on the edge that closes the previous instruction
    assign rs1_tag_o = map_q[rs1_i];
    assign rs2_tag_o = map_q[rs2_i];
    assign old_tag_o = map_q[rd_i];

    // x0 must keep tag 0
    a_no_x0_rename: assert property (@(posedge clock) disable iff (reset)
        write_i |-> (rd_i != '0));

endmodule

`default_nettype wire

// File: verilog/dispatch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module dispatch_stage (
    input  wire logic              clock,
    input  wire logic              reset,
    // decoded instruction and its lookups
    input  wire logic              inst_valid_i,
    input  wire logic              has_dest_i,
    input  rename_pkg::fu_type_t   fu_type_i,
    input  rename_pkg::arch_reg_t  rd_i,
    input  rename_pkg::phys_tag_t  rs1_tag_i,
    input  rename_pkg::phys_tag_t  rs2_tag_i,
    input  rename_pkg::phys_tag_t  old_tag_i,
    // free list, reorder buffer, commit
    input  rename_pkg::phys_tag_t  free_tag_i,
    input  wire logic              free_empty_i,
    input  wire logic              rob_full_i,
    input  rename_pkg::rob_idx_t   rob_idx_i,
    input  wire logic              commit_i,
    input  rename_pkg::rob_entry_t rob_head_i,
    // resource updates
    output logic                   alloc_o,
    output logic                   map_write_o,
    output logic                   rob_push_o,
    output rename_pkg::rob_entry_t rob_entry_o,
    output logic                   rob_pop_o,
    output logic                   recycle_o,
    output rename_pkg::phys_tag_t  recycle_tag_o,
    output logic                   stall_o,
    // dispatch packet, one cycle after inst_valid_i
    output logic                   disp_valid_o,
    output rename_pkg::rob_idx_t   disp_rob_idx_o,
    output rename_pkg::phys_tag_t  disp_dest_tag_o,
    output rename_pkg::phys_tag_t  disp_old_tag_o,
    output rename_pkg::phys_tag_t  disp_src1_tag_o,
    output rename_pkg::phys_tag_t  disp_src2_tag_o,
    output rename_pkg::fu_type_t   disp_fu_type_o,
    // freed tag report, one cycle after commit_i
    output logic                   free_valid_o,
    output rename_pkg::phys_tag_t  freed_tag_o
);

    logic accept;  // instruction renamed this cycle

    // ==========================================================
    // resource check and rename sequencing
    // ==========================================================

    // free list test applies to every instruction, dest or not
    assign stall_o = free_empty_i || rob_full_i;
    assign accept  = inst_valid_i && !stall_o;

    assign alloc_o     = accept && has_dest_i;  // pop head of free list
    assign map_write_o = alloc_o;               // rd -> popped tag, same edge
    assign rob_push_o  = accept;                // every instruction gets a slot
    assign rob_entry_o = '{has_dest: has_dest_i, dest_arch: rd_i, old_tag: old_tag_i};

    // commit retires the head, Told goes back to the pool
    assign rob_pop_o     = commit_i;
    assign recycle_o     = commit_i && rob_head_i.has_dest;
    assign recycle_tag_o = rob_head_i.old_tag;

    // ==========================================================
    // registered outputs
    // ==========================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            disp_valid_o <= 1'b0;
            free_valid_o <= 1'b0;
        end else begin
            disp_valid_o <= accept;
            free_valid_o <= recycle_o;
        end
    end

    // packet payload, no reset
    always_ff @(posedge clock) begin
        if (accept) begin
            disp_rob_idx_o  <= rob_idx_i;
            disp_dest_tag_o <= has_dest_i ? free_tag_i : '0;  // zero when nothing renamed
            disp_old_tag_o  <= has_dest_i ? old_tag_i : '0;
            disp_src1_tag_o <= rs1_tag_i;
            disp_src2_tag_o <= rs2_tag_i;
            disp_fu_type_o  <= fu_type_i;
        end
        if (recycle_o) freed_tag_o <= recycle_tag_o;
    end

    // source must hold off while stalled, nothing is buffered here
    a_no_inst_on_stall: assert property (@(posedge clock) disable iff (reset)
        inst_valid_i |-> !stall_o);

endmodule

`default_nettype wire

// File: verilog/rename_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rename_dispatch (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             inst_valid_i,
    input  wire logic [31:0]      inst_i,
    input  wire logic             commit_i,
    output logic                  stall_o,
    output logic                  disp_valid_o,
    output rename_pkg::rob_idx_t  disp_rob_idx_o,
    output rename_pkg::phys_tag_t disp_dest_tag_o,
    output rename_pkg::phys_tag_t disp_old_tag_o,
    output rename_pkg::phys_tag_t disp_src1_tag_o,
    output rename_pkg::phys_tag_t disp_src2_tag_o,
    output rename_pkg::fu_type_t  disp_fu_type_o,
    output logic                  free_valid_o,
    output rename_pkg::phys_tag_t freed_tag_o
);

    // decode
    rename_pkg::arch_reg_t  rs1, rs2, rd;
    logic                   has_dest;
    rename_pkg::fu_type_t   fu_type;
    // map table
    rename_pkg::phys_tag_t  rs1_tag, rs2_tag, old_tag;
    // free list
    rename_pkg::phys_tag_t  free_tag;
    logic                   free_empty;
    // reorder buffer
    rename_pkg::rob_entry_t rob_head;
    logic                   rob_full;
    rename_pkg::rob_idx_t   rob_idx;
    // dispatch control
    logic                   alloc, map_write, rob_push, rob_pop, recycle;
    rename_pkg::rob_entry_t rob_entry;
    rename_pkg::phys_tag_t  recycle_tag;

    // ==========================================================
    // decode and map lookup
    // ==========================================================
    inst_decoder u_inst_decoder (
        .inst_i(inst_i), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd),
        .has_dest_o(has_dest), .fu_type_o(fu_type)
    );

    map_table u_map_table (
        .clock(clock), .reset(reset),
        .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd),
        .write_i(map_write), .write_tag_i(free_tag),  // head of free list is the new tag
        .rs1_tag_o(rs1_tag), .rs2_tag_o(rs2_tag), .old_tag_o(old_tag)
    );

    // ==========================================================
    // free list and reorder buffer
    // ==========================================================
    circular_queue #(
        .DEPTH(`PHYS_REGS - `ARCH_REGS), .payload_t(rename_pkg::phys_tag_t),
        .RESET_FILL(1'b1), .FILL_BASE(`ARCH_REGS)     // tags 32..47
    ) u_free_list (
        .clock(clock), .reset(reset),
        .push_i(recycle), .push_data_i(recycle_tag), .pop_i(alloc),
        .head_o(free_tag), .empty_o(free_empty), .full_o(), .tail_idx_o()
    );

    circular_queue #(
        .DEPTH(`ROB_DEPTH), .payload_t(rename_pkg::rob_entry_t)
    ) u_rob (
        .clock(clock), .reset(reset),
        .push_i(rob_push), .push_data_i(rob_entry), .pop_i(rob_pop),
        .head_o(rob_head), .empty_o(), .full_o(rob_full), .tail_idx_o(rob_idx)
    );

    // ==========================================================
    // dispatch
    // ==========================================================
    dispatch_stage u_dispatch_stage (
        .clock(clock), .reset(reset),
        .inst_valid_i(inst_valid_i), .has_dest_i(has_dest), .fu_type_i(fu_type), .rd_i(rd),
        .rs1_tag_i(rs1_tag), .rs2_tag_i(rs2_tag), .old_tag_i(old_tag),
        .free_tag_i(free_tag), .free_empty_i(free_empty), .rob_full_i(rob_full),
        .rob_idx_i(rob_idx), .commit_i(commit_i), .rob_head_i(rob_head),
        .alloc_o(alloc), .map_write_o(map_write), .rob_push_o(rob_push),
        .rob_entry_o(rob_entry), .rob_pop_o(rob_pop),
        .recycle_o(recycle), .recycle_tag_o(recycle_tag), .stall_o(stall_o),
        .disp_valid_o(disp_valid_o), .disp_rob_idx_o(disp_rob_idx_o),
        .disp_dest_tag_o(disp_dest_tag_o), .disp_old_tag_o(disp_old_tag_o),
        .disp_src1_tag_o(disp_src1_tag_o), .disp_src2_tag_o(disp_src2_tag_o),
        .disp_fu_type_o(disp_fu_type_o),
        .free_valid_o(free_valid_o), .freed_tag_o(freed_tag_o)
    );

endmodule

`default_nettype wire

// File: testbench/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
    parameter int HALF_PERIOD  = 20,  // 40 ns clock
    parameter int RESET_CYCLES = 16
) (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever #HALF_PERIOD clock_o = ~clock_o;
    end

    // released on a rising edge, like any other synchronous input
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_o);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire

// File: testbench/dispatch_checker.sv
`timescale 1ns/1ns
`default_nettype none

module dispatch_checker (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             stall_i,
    input  wire logic             exp_stall_i,    // reference model's stall for this cycle
    input  wire logic             disp_valid_i,
    input  rename_pkg::rob_idx_t  disp_rob_idx_i,
    input  rename_pkg::phys_tag_t disp_dest_tag_i,
    input  rename_pkg::phys_tag_t disp_old_tag_i,
    input  rename_pkg::phys_tag_t disp_src1_tag_i,
    input  rename_pkg::phys_tag_t disp_src2_tag_i,
    input  rename_pkg::fu_type_t  disp_fu_type_i,
    input  wire logic             free_valid_i,
    input  rename_pkg::phys_tag_t freed_tag_i
);

    // expected packet {rob_idx, dest, old, src1, src2, fu}
    logic [29:0]           exp_disp_q [$];
    rename_pkg::phys_tag_t exp_free_q [$];  // freed tags in commit order
    int                    value_errors = 0;
    int                    event_errors = 0;

    task automatic expect_disp(input rename_pkg::rob_idx_t idx, input rename_pkg::phys_tag_t dest,
                               input rename_pkg::phys_tag_t old, input rename_pkg::phys_tag_t s1,
                               input rename_pkg::phys_tag_t s2, input rename_pkg::fu_type_t fu);
        exp_disp_q.push_back({idx, dest, old, s1, s2, fu});
    endtask

    task automatic expect_free(input rename_pkg::phys_tag_t tag);
        exp_free_q.push_back(tag);
    endtask

    function automatic int pending_count();
        return exp_disp_q.size() + exp_free_q.size();
    endfunction

    task automatic check_field(input string name, input logic [7:0] exp_v,
                               input logic [7:0] got_v);
        if (got_v !== exp_v) begin
            $display("[ERROR] %s expected %h got %h at %0t", name, exp_v, got_v, $time);
            value_errors++;
        end
    endtask

    // ============================================================
    // compare mid-cycle, outputs settled
    // ============================================================
    always @(negedge clock) begin
        logic [29:0] pkt;
        if (!reset) begin
            check_field("stall_o", 8'(exp_stall_i), 8'(stall_i));
            if (disp_valid_i !== 1'b0) begin
                if (exp_disp_q.size() == 0) begin
                    $display("dispatch packet at %0t that no instruction accounts for", $time);
                    event_errors++;
                end else begin
                    pkt = exp_disp_q.pop_front();
                    check_field("disp_rob_idx_o",  8'(pkt[29:26]), 8'(disp_rob_idx_i));
                    check_field("disp_dest_tag_o", 8'(pkt[25:20]), 8'(disp_dest_tag_i));
                    check_field("disp_old_tag_o",  8'(pkt[19:14]), 8'(disp_old_tag_i));
                    check_field("disp_src1_tag_o", 8'(pkt[13:8]),  8'(disp_src1_tag_i));
                    check_field("disp_src2_tag_o", 8'(pkt[7:2]),   8'(disp_src2_tag_i));
                    check_field("disp_fu_type_o",  8'(pkt[1:0]),   8'(disp_fu_type_i));
                end
            end
            if (free_valid_i !== 1'b0) begin
                if (exp_free_q.size() == 0) begin
                    $display("freed tag reported at %0t without a matching commit", $time);
                    event_errors++;
                end else begin
                    check_field("freed_tag_o", 8'(exp_free_q.pop_front()), 8'(freed_tag_i));
                end
            end
        end
    end

    // called once at the end of the run
    task automatic report_leftovers();
        if (exp_disp_q.size() != 0) begin
            $display("%0d expected dispatch packets never came out", exp_disp_q.size());
            event_errors += exp_disp_q.size();
        end
        if (exp_free_q.size() != 0) begin
            $display("%0d expected freed tags never came out", exp_free_q.size());
            event_errors += exp_free_q.size();
        end
    endtask

endmodule

`default_nettype wire

// File: testbench/rename_dispatch_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rename_dispatch_tb;

    localparam int          NUM_ROWS       = 46;
    localparam int          TIMEOUT_CYCLES = NUM_ROWS * 4 + 100;
    localparam logic [31:0] LCG_SEED       = 32'd6;

    localparam int ACT_INST   = 0;
    localparam int ACT_COMMIT = 1;
    localparam int ACT_IDLE   = 2;
    localparam int FIX_REGS   = 0;  // register fields as written
    localparam int RAND_SRC   = 1;  // rs1, rs2 from the generator
    localparam int RAND_ALL   = 2;  // rs1, rs2 and rd

    // rv32 opcodes
    localparam int OPC_REG = 'h33, OPC_IMM = 'h13, OPC_LOAD = 'h03;
    localparam int OPC_STORE = 'h23, OPC_BRANCH = 'h63, OPC_JAL = 'h6f;

    localparam rename_pkg::fu_type_t FU_ALU    = rename_pkg::fu_alu;
    localparam rename_pkg::fu_type_t FU_MULT   = rename_pkg::fu_mult;
    localparam rename_pkg::fu_type_t FU_MEM    = rename_pkg::fu_mem;
    localparam rename_pkg::fu_type_t FU_BRANCH = rename_pkg::fu_branch;

    logic                  clock, reset;
    logic                  inst_valid, commit, exp_stall;
    logic [31:0]           inst;
    logic                  stall, disp_valid, free_valid;
    rename_pkg::rob_idx_t  disp_rob_idx;
    rename_pkg::phys_tag_t disp_dest_tag, disp_old_tag, disp_src1_tag, disp_src2_tag, freed_tag;
    rename_pkg::fu_type_t  disp_fu_type;

    // stimulus table, expected fu class and rd presence per row
    int                    row_action [NUM_ROWS];
    logic [31:0]           row_inst   [NUM_ROWS];
    int                    row_mode   [NUM_ROWS];
    rename_pkg::fu_type_t  row_fu     [NUM_ROWS];
    int                    row_writes [NUM_ROWS];  // opcode has an rd field
    int                    row_count;

    // reference rename model
    rename_pkg::phys_tag_t ref_map [`ARCH_REGS];
    rename_pkg::phys_tag_t ref_free_q [$];
    logic [6:0]            ref_rob_q [$];          // {has_dest, old_tag}
    rename_pkg::rob_idx_t  ref_rob_tail;
    logic [31:0]           lcg_state;
    int                    cycle_count;
    int                    table_errors;

    clock_gen u_clock_gen (.clock_o(clock), .reset_o(reset));

    rename_dispatch u_rename_dispatch (
        .clock(clock), .reset(reset), .inst_valid_i(inst_valid), .inst_i(inst),
        .commit_i(commit), .stall_o(stall), .disp_valid_o(disp_valid),
        .disp_rob_idx_o(disp_rob_idx), .disp_dest_tag_o(disp_dest_tag),
        .disp_old_tag_o(disp_old_tag), .disp_src1_tag_o(disp_src1_tag),
        .disp_src2_tag_o(disp_src2_tag), .disp_fu_type_o(disp_fu_type),
        .free_valid_o(free_valid), .freed_tag_o(freed_tag)
    );

    dispatch_checker u_dispatch_checker (
        .clock(clock), .reset(reset), .stall_i(stall), .exp_stall_i(exp_stall),
        .disp_valid_i(disp_valid), .disp_rob_idx_i(disp_rob_idx),
        .disp_dest_tag_i(disp_dest_tag), .disp_old_tag_i(disp_old_tag),
        .disp_src1_tag_i(disp_src1_tag), .disp_src2_tag_i(disp_src2_tag),
        .disp_fu_type_i(disp_fu_type), .free_valid_i(free_valid), .freed_tag_i(freed_tag)
    );

    function automatic logic [31:0] enc(input int f7, input int rs2, input int rs1,
                                        input int rd, input int opc);
        return {f7[6:0], rs2[4:0], rs1[4:0], 3'b000, rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [4:0] lcg_reg();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[20:16];  // upper bits, low ones cycle fast
    endfunction

    function automatic logic model_stall();
        return (ref_free_q.size() == 0) || (ref_rob_q.size() == `ROB_DEPTH);
    endfunction

    task automatic add_row(input int act, input logic [31:0] ins, input int mode,
                           input rename_pkg::fu_type_t fu, input int wr);
        row_action[row_count] = act;
        row_inst[row_count]   = ins;
        row_mode[row_count]   = mode;
        row_fu[row_count]     = fu;
        row_writes[row_count] = wr;
        row_count++;
    endtask

    // ============================================================
    // stimulus table
    // ============================================================
    task automatic build_table();
        add_row(ACT_INST, enc(0, 2, 1, 5, OPC_REG), FIX_REGS, FU_ALU, 1);     // add x5, x1, x2
        add_row(ACT_INST, enc(0, 5, 5, 6, OPC_REG), FIX_REGS, FU_ALU, 1);     // reads new x5
        add_row(ACT_INST, enc(0, 3, 5, 5, OPC_IMM), FIX_REGS, FU_ALU, 1);     // x5 again
        add_row(ACT_INST, enc(0, 6, 5, 4, OPC_STORE), FIX_REGS, FU_MEM, 0);   // sw x6, 4(x5)
        add_row(ACT_INST, enc(0, 6, 5, 8, OPC_BRANCH), FIX_REGS, FU_BRANCH, 0);
        add_row(ACT_INST, enc(0, 2, 1, 0, OPC_REG), FIX_REGS, FU_ALU, 1);     // rd = x0
        add_row(ACT_INST, enc(1, 6, 5, 7, OPC_REG), FIX_REGS, FU_MULT, 1);    // mul
        add_row(ACT_INST, enc(0, 0, 5, 8, OPC_LOAD), FIX_REGS, FU_MEM, 1);
        add_row(ACT_INST, enc(0, 0, 0, 1, OPC_JAL), FIX_REGS, FU_BRANCH, 1);
        // retire all nine, one gap
        for (int i = 0; i < 10; i++) begin
            add_row((i == 2) ? ACT_IDLE : ACT_COMMIT, '0, FIX_REGS, FU_ALU, 0);
        end
        // 16 renames, no commits, drains the free list
        for (int i = 0; i < 16; i++) begin
            add_row(ACT_INST, enc(i % 2, 0, 0, 10 + i, OPC_REG), RAND_SRC,
                    (i % 2 != 0) ? FU_MULT : FU_ALU, 1);
        end
        add_row(ACT_INST, enc(0, 1, 1, 26, OPC_REG), FIX_REGS, FU_ALU, 1);   // stalled, skipped
        add_row(ACT_COMMIT, '0, FIX_REGS, FU_ALU, 0);
        add_row(ACT_INST, enc(0, 0, 0, 0, OPC_REG), RAND_ALL, FU_ALU, 1);     // recycled tag
        // random mix with commits in between
        add_row(ACT_COMMIT, '0, FIX_REGS, FU_ALU, 0);
        add_row(ACT_INST, enc(1, 0, 0, 0, OPC_REG), RAND_ALL, FU_MULT, 1);
        add_row(ACT_COMMIT, '0, FIX_REGS, FU_ALU, 0);
        add_row(ACT_INST, enc(0, 0, 0, 0, OPC_LOAD), RAND_ALL, FU_MEM, 1);
        add_row(ACT_COMMIT, '0, FIX_REGS, FU_ALU, 0);
        add_row(ACT_INST, enc(0, 0, 0, 0, OPC_STORE), RAND_ALL, FU_MEM, 0);
        add_row(ACT_COMMIT, '0, FIX_REGS, FU_ALU, 0);
        add_row(ACT_INST, enc(0, 0, 0, 0, OPC_BRANCH), RAND_ALL, FU_BRANCH, 0);
    endtask

    task automatic next_cycle();
        @(posedge clock);
        inst_valid <= 1'b0;
        commit     <= 1'b0;
        exp_stall  <= model_stall();  // model state matches the DUT after this edge
    endtask

    task automatic apply_inst(input int n);
        logic [31:0]           ins;
        logic                  hd;
        rename_pkg::phys_tag_t dest;
        rename_pkg::phys_tag_t old;
        ins = row_inst[n];
        if (row_mode[n] != FIX_REGS) begin
            ins[19:15] = lcg_reg();
            ins[24:20] = lcg_reg();
        end
        if (row_mode[n] == RAND_ALL) ins[11:7] = lcg_reg();
        hd   = (row_writes[n] != 0) && (ins[11:7] != 5'd0);  // x0 renames nothing
        dest = '0;
        old  = '0;
        if (hd) begin
            dest = ref_free_q.pop_front();
            old  = ref_map[ins[11:7]];
        end
        // sources see the mapping before this rename
        u_dispatch_checker.expect_disp(ref_rob_tail, dest, old, ref_map[ins[19:15]],
                                       ref_map[ins[24:20]], row_fu[n]);
        if (hd) ref_map[ins[11:7]] = dest;
        ref_rob_q.push_back({hd, old});
        ref_rob_tail++;  // wraps at 16
        inst_valid <= 1'b1;
        inst       <= ins;
    endtask

    task automatic apply_commit();
        logic [6:0] entry;
        entry = ref_rob_q.pop_front();
        if (entry[6]) begin
            ref_free_q.push_back(entry[5:0]);  // back of the pool
            u_dispatch_checker.expect_free(entry[5:0]);
        end
        commit <= 1'b1;
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        inst_valid   = 1'b0;
        inst         = '0;
        commit       = 1'b0;
        exp_stall    = 1'b0;
        lcg_state    = LCG_SEED;
        row_count    = 0;
        table_errors = 0;
        ref_rob_tail = '0;
        for (int r = 0; r < `ARCH_REGS; r++) ref_map[r] = rename_pkg::phys_tag_t'(r);
        for (int t = `ARCH_REGS; t < `PHYS_REGS; t++) begin
            ref_free_q.push_back(rename_pkg::phys_tag_t'(t));
        end
        build_table();
        if (row_count != NUM_ROWS) begin
            $display("stimulus table holds %0d rows instead of %0d", row_count, NUM_ROWS);
            table_errors++;
        end

        @(negedge clock);
        while (reset) @(negedge clock);

        for (int n = 0; n < NUM_ROWS; n++) begin
            next_cycle();
            if (row_action[n] == ACT_COMMIT && ref_rob_q.size() != 0) begin
                apply_commit();
            end else if (row_action[n] == ACT_INST && !model_stall()) begin
                apply_inst(n);
            end
        end

        // drain the last packet and freed tag
        for (int w = 0; w < 8 && u_dispatch_checker.pending_count() != 0; w++) next_cycle();
        @(negedge clock);
        u_dispatch_checker.report_leftovers();
        $display("errors: %0d value, %0d event, %0d table", u_dispatch_checker.value_errors,
                 u_dispatch_checker.event_errors, table_errors);
        if (u_dispatch_checker.value_errors + u_dispatch_checker.event_errors
                + table_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // hang guard
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout, run still going after %0d cycles", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rename_dispatch.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/inst_decoder.sv
verilog/circular_queue.sv
verilog/map_table.sv
verilog/dispatch_stage.sv
verilog/rename_dispatch.sv
testbench/clock_gen.sv
testbench/dispatch_checker.sv
testbench/rename_dispatch_tb.sv
